//--- rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data and address width
`define RV_XLEN 32

// Register file geometry
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// PC value held by an empty ID/EX stage
`define RV_RESET_PC 32'h0000_0000

`endif

//--- rv_pkg.sv
package rv_pkg;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10  // LUI
    } alu_ctrl_t;

    // Same encoding as the branch funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_func_t;

    typedef enum logic [1:0] {
        PC_INC    = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JUMP   = 2'd2
    } pc_source_t;

endpackage

//--- id_ex_if.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

interface id_ex_if;

    // Register addresses
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rd;

    // Writeback
    logic mem_to_reg;
    logic reg_write;

    // Memory
    logic mem_write;
    logic mem_read;
    logic jal;
    logic lui;

    // Execute
    rv_pkg::alu_ctrl_t  alu_ctrl;
    logic               alu_pc;    // Operand A is the PC
    logic               alu_imm;   // Operand B is the immediate
    rv_pkg::br_func_t   br_func;
    logic               jal_addr;  // Target from rs1 (JALR)
    rv_pkg::pc_source_t pc_source;

    // Datapath
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] sext_out;

    modport producer (
        output rs1, rs2, rd, mem_to_reg, reg_write, mem_write, mem_read, jal, lui,
        output alu_ctrl, alu_pc, alu_imm, br_func, jal_addr, pc_source,
        output pc, rs1_data, rs2_data, sext_out
    );

    modport consumer (
        input rs1, rs2, rd, mem_to_reg, reg_write, mem_write, mem_read, jal, lui,
        input alu_ctrl, alu_pc, alu_imm, br_func, jal_addr, pc_source,
        input pc, rs1_data, rs2_data, sext_out
    );

endinterface

//--- decode_stage.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [31:0]           instr,
    input  logic [`RV_XLEN-1:0]   pc,
    input  logic                  wb_en,
    input  logic [`RV_REG_AW-1:0] wb_rd,
    input  logic [`RV_XLEN-1:0]   wb_data,
    id_ex_if.producer             id
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    rv_pkg::opcode_t     opcode;
    logic [2:0]          funct3;
    logic                f7b5;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic                wr_en;

    assign opcode = rv_pkg::opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign f7b5   = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct7 bit 5 picks SUB only for register ops, SRA for both
    function automatic rv_pkg::alu_ctrl_t alu_decode(input logic [2:0] f3,
                                                     input logic       alt,
                                                     input logic       is_reg);
        case (f3)
            3'b000:  alu_decode = (is_reg && alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  alu_decode = rv_pkg::ALU_SLL;
            3'b010:  alu_decode = rv_pkg::ALU_SLT;
            3'b011:  alu_decode = rv_pkg::ALU_SLTU;
            3'b100:  alu_decode = rv_pkg::ALU_XOR;
            3'b101:  alu_decode = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  alu_decode = rv_pkg::ALU_OR;
            default: alu_decode = rv_pkg::ALU_AND;
        endcase
    endfunction

    // Write-through read, x0 hardwired to zero
    function automatic logic [`RV_XLEN-1:0] rf_read(input logic [`RV_REG_AW-1:0] addr);
        if (addr == '0)
            rf_read = '0;
        else if (wb_en && wb_rd == addr)
            rf_read = wb_data;
        else
            rf_read = regs[addr];
    endfunction

    always_comb begin
        id.mem_to_reg = 1'b0;  // Defaults form a NOP
        wr_en         = 1'b0;
        id.mem_write  = 1'b0;
        id.mem_read   = 1'b0;
        id.jal        = 1'b0;
        id.lui        = 1'b0;
        id.alu_ctrl   = rv_pkg::ALU_ADD;
        id.alu_pc     = 1'b0;
        id.alu_imm    = 1'b0;
        id.br_func    = rv_pkg::BR_EQ;
        id.jal_addr   = 1'b0;
        id.pc_source  = rv_pkg::PC_INC;
        id.sext_out   = '0;
        case (opcode)
            rv_pkg::OP: begin
                wr_en       = 1'b1;
                id.alu_ctrl = alu_decode(funct3, f7b5, 1'b1);
            end
            rv_pkg::OP_IMM: begin
                wr_en       = 1'b1;
                id.alu_imm  = 1'b1;
                id.alu_ctrl = alu_decode(funct3, f7b5, 1'b0);
                id.sext_out = imm_i;
            end
            rv_pkg::LUI: begin
                wr_en       = 1'b1;
                id.lui      = 1'b1;
                id.alu_imm  = 1'b1;
                id.alu_ctrl = rv_pkg::ALU_PASS_B;
                id.sext_out = imm_u;
            end
            rv_pkg::AUIPC: begin
                wr_en       = 1'b1;
                id.alu_pc   = 1'b1;
                id.alu_imm  = 1'b1;
                id.sext_out = imm_u;
            end
            rv_pkg::LOAD: begin
                wr_en         = 1'b1;
                id.mem_read   = 1'b1;
                id.mem_to_reg = 1'b1;
                id.alu_imm    = 1'b1;
                id.sext_out   = imm_i;
            end
            rv_pkg::STORE: begin
                id.mem_write = 1'b1;
                id.alu_imm   = 1'b1;
                id.sext_out  = imm_s;
            end
            rv_pkg::BRANCH: begin
                id.pc_source = rv_pkg::PC_BRANCH;
                id.br_func   = rv_pkg::br_func_t'(funct3);
                id.sext_out  = imm_b;
            end
            rv_pkg::JAL: begin
                wr_en        = 1'b1;
                id.jal       = 1'b1;
                id.pc_source = rv_pkg::PC_JUMP;
                id.sext_out  = imm_j;
            end
            rv_pkg::JALR: begin
                wr_en        = 1'b1;
                id.jal       = 1'b1;
                id.jal_addr  = 1'b1;
                id.alu_imm   = 1'b1;
                id.pc_source = rv_pkg::PC_JUMP;
                id.sext_out  = imm_i;
            end
            default: ;  // Illegal opcode stays a NOP
        endcase
    end

    // No write for rd = x0, so 32'h00000013 is a bubble
    assign id.reg_write = wr_en && (instr[11:7] != 5'd0);

    assign id.rs1 = instr[19:15];
    assign id.rs2 = instr[24:20];
    assign id.rd  = instr[11:7];
    assign id.pc  = pc;

    always_comb begin
        id.rs1_data = rf_read(instr[19:15]);
        id.rs2_data = rf_read(instr[24:20]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

//--- id_ex_buffer.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module id_ex_buffer (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    id_ex_if.consumer id,
    id_ex_if.producer ex
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Bubble
            ex.rs1        <= '0;
            ex.rs2        <= '0;
            ex.rd         <= '0;
            ex.mem_to_reg <= 1'b0;
            ex.reg_write  <= 1'b0;
            ex.mem_write  <= 1'b0;
            ex.mem_read   <= 1'b0;
            ex.jal        <= 1'b0;
            ex.lui        <= 1'b0;
            ex.alu_ctrl   <= rv_pkg::ALU_ADD;
            ex.alu_pc     <= 1'b0;
            ex.alu_imm    <= 1'b0;
            ex.br_func    <= rv_pkg::BR_EQ;
            ex.jal_addr   <= 1'b0;
            ex.pc_source  <= rv_pkg::PC_INC;
            ex.pc         <= `RV_RESET_PC;
            ex.rs1_data   <= '0;
            ex.rs2_data   <= '0;
            ex.sext_out   <= '0;
        end else if (!stall) begin
            ex.rs1        <= id.rs1;
            ex.rs2        <= id.rs2;
            ex.rd         <= id.rd;
            ex.mem_to_reg <= id.mem_to_reg;
            ex.reg_write  <= id.reg_write;
            ex.mem_write  <= id.mem_write;
            ex.mem_read   <= id.mem_read;
            ex.jal        <= id.jal;
            ex.lui        <= id.lui;
            ex.alu_ctrl   <= id.alu_ctrl;
            ex.alu_pc     <= id.alu_pc;
            ex.alu_imm    <= id.alu_imm;
            ex.br_func    <= id.br_func;
            ex.jal_addr   <= id.jal_addr;
            ex.pc_source  <= id.pc_source;
            ex.pc         <= id.pc;
            ex.rs1_data   <= id.rs1_data;
            ex.rs2_data   <= id.rs2_data;
            ex.sext_out   <= id.sext_out;
        end
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module execute_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    id_ex_if.consumer             ex,
    output logic [`RV_XLEN-1:0]   alu_result,
    output logic [`RV_XLEN-1:0]   store_data,
    output logic [`RV_REG_AW-1:0] rd,
    output logic                  reg_write,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  mem_to_reg,
    output logic                  redirect,
    output logic [`RV_XLEN-1:0]   target
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_out;
    logic [`RV_XLEN-1:0] result;
    logic [`RV_XLEN-1:0] jump_target;
    logic                br_taken;
    logic                take;

    assign op_a  = ex.alu_pc ? ex.pc : ex.rs1_data;
    assign op_b  = ex.alu_imm ? ex.sext_out : ex.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex.alu_ctrl)
            rv_pkg::ALU_ADD:    alu_out = op_a + op_b;
            rv_pkg::ALU_SUB:    alu_out = op_a - op_b;
            rv_pkg::ALU_SLL:    alu_out = op_a << shamt;
            rv_pkg::ALU_SLT:    alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU:   alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            rv_pkg::ALU_SRL:    alu_out = op_a >> shamt;
            rv_pkg::ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:     alu_out = op_a | op_b;
            rv_pkg::ALU_AND:    alu_out = op_a & op_b;
            rv_pkg::ALU_PASS_B: alu_out = op_b;
            default:            alu_out = '0;
        endcase
    end

    assign result = ex.jal ? ex.pc + `RV_XLEN'd4 : alu_out;  // Link address

    always_comb begin
        case (ex.br_func)
            rv_pkg::BR_EQ:  br_taken = ex.rs1_data == ex.rs2_data;
            rv_pkg::BR_NE:  br_taken = ex.rs1_data != ex.rs2_data;
            rv_pkg::BR_LT:  br_taken = $signed(ex.rs1_data) < $signed(ex.rs2_data);
            rv_pkg::BR_GE:  br_taken = $signed(ex.rs1_data) >= $signed(ex.rs2_data);
            rv_pkg::BR_LTU: br_taken = ex.rs1_data < ex.rs2_data;
            rv_pkg::BR_GEU: br_taken = ex.rs1_data >= ex.rs2_data;
            default:        br_taken = 1'b0;
        endcase
    end

    // JALR clears bit 0 of rs1 + imm
    assign jump_target = ex.jal_addr ? (ex.rs1_data + ex.sext_out) & ~`RV_XLEN'd1
                                     : ex.pc + ex.sext_out;

    assign take = (ex.pc_source == rv_pkg::PC_JUMP) ||
                  (ex.pc_source == rv_pkg::PC_BRANCH && br_taken);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_result <= '0;
            store_data <= '0;
            rd         <= '0;
            reg_write  <= 1'b0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
            mem_to_reg <= 1'b0;
            redirect   <= 1'b0;
            target     <= '0;
        end else if (!stall) begin
            alu_result <= result;
            store_data <= ex.rs2_data;
            rd         <= ex.rd;
            reg_write  <= ex.reg_write;
            mem_read   <= ex.mem_read;
            mem_write  <= ex.mem_write;
            mem_to_reg <= ex.mem_to_reg;
            redirect   <= take;
            target     <= jump_target;
        end
    end

endmodule

//--- rv_id_ex_top.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_id_ex_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [31:0]           instr,
    input  logic [`RV_XLEN-1:0]   pc,
    input  logic                  stall,
    input  logic                  wb_en,
    input  logic [`RV_REG_AW-1:0] wb_rd,
    input  logic [`RV_XLEN-1:0]   wb_data,
    output logic [`RV_XLEN-1:0]   ex_alu_result,
    output logic [`RV_XLEN-1:0]   ex_store_data,
    output logic [`RV_REG_AW-1:0] ex_rd,
    output logic                  ex_reg_write,
    output logic                  ex_mem_read,
    output logic                  ex_mem_write,
    output logic                  ex_mem_to_reg,
    output logic                  ex_redirect,
    output logic [`RV_XLEN-1:0]   ex_target
);

    id_ex_if id_if ();  // Decode to ID/EX
    id_ex_if ex_if ();  // ID/EX to execute

    decode_stage decode_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .instr   (instr),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .id      (id_if.producer)
    );

    id_ex_buffer id_ex_buffer_i (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .id    (id_if.consumer),
        .ex    (ex_if.producer)
    );

    execute_stage execute_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .ex         (ex_if.consumer),
        .alu_result (ex_alu_result),
        .store_data (ex_store_data),
        .rd         (ex_rd),
        .reg_write  (ex_reg_write),
        .mem_read   (ex_mem_read),
        .mem_write  (ex_mem_write),
        .mem_to_reg (ex_mem_to_reg),
        .redirect   (ex_redirect),
        .target     (ex_target)
    );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen #(
    parameter real PERIOD = 8.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2.0) clk = ~clk;

endmodule

//--- tb_rv_id_ex.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module tb_rv_id_ex;

    localparam logic [31:0] NOP = 32'h0000_0013;
    localparam int N_INSTR = 230;                       // Upper bound of driven cycles
    localparam real TIMEOUT = (N_INSTR * 4 + 200) * 8.0;

    typedef struct packed {
        logic [31:0] alu;
        logic [31:0] sdata;
        logic [31:0] tgt;
        logic [4:0]  rd;
        logic        rw;
        logic        mr;
        logic        mw;
        logic        m2r;
        logic        redir;
        logic        chk_alu;
        logic        chk_tgt;
        logic [31:0] issue;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        stall;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic [31:0] ex_alu_result;
    logic [31:0] ex_store_data;
    logic [4:0]  ex_rd;
    logic        ex_reg_write;
    logic        ex_mem_read;
    logic        ex_mem_write;
    logic        ex_mem_to_reg;
    logic        ex_redirect;
    logic [31:0] ex_target;

    logic [31:0] shadow [32];
    logic [31:0] lfsr = 32'h9aff;
    logic [31:0] cur_pc = 32'h0000_1000;
    exp_t        q [$];
    exp_t        last_snap;
    int          adv = 0;      // Non-stalled edges since reset
    logic        stall_seen = 1'b0;
    int          errors = 0;
    int          n_checks = 0;

    tb_clkgen #(.PERIOD(8.0)) tb_clkgen_i (.clk(clk));

    rv_id_ex_top rv_id_ex_top_i (.*);

    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic is_reg, input logic [31:0] a,
                                            input logic [31:0] b);
        case (f3)
            3'd0: return (is_reg && alt) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Expected outputs of one instruction from the RV32I rules
    function automatic exp_t ref_exec(input logic [31:0] ins, input logic [31:0] ipc,
                                      input logic [31:0] a, input logic [31:0] b);
        exp_t e;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        e = '0;
        e.rd = ins[11:7];
        e.sdata = b;
        e.chk_alu = 1'b1;
        case (ins[6:0])
            7'b0110011: begin
                e.rw = 1'b1;
                e.alu = alu_ref(ins[14:12], ins[30], 1'b1, a, b);
            end
            7'b0010011: begin
                e.rw = 1'b1;
                e.alu = alu_ref(ins[14:12], ins[30], 1'b0, a, imm_i);
            end
            7'b0110111: begin
                e.rw = 1'b1;
                e.alu = imm_u;
            end
            7'b0010111: begin
                e.rw = 1'b1;
                e.alu = ipc + imm_u;
            end
            7'b0000011: begin
                {e.rw, e.mr, e.m2r} = 3'b111;
                e.alu = a + imm_i;
            end
            7'b0100011: begin
                e.mw = 1'b1;
                e.alu = a + imm_s;
            end
            7'b1100011: begin
                e.chk_alu = 1'b0;
                e.chk_tgt = 1'b1;
                e.tgt = ipc + imm_b;
                case (ins[14:12])
                    3'd0: e.redir = a == b;
                    3'd1: e.redir = a != b;
                    3'd4: e.redir = $signed(a) < $signed(b);
                    3'd5: e.redir = $signed(a) >= $signed(b);
                    3'd6: e.redir = a < b;
                    default: e.redir = a >= b;
                endcase
            end
            default: begin  // JAL and JALR
                {e.rw, e.redir, e.chk_tgt} = 3'b111;
                e.alu = ipc + 32'd4;
                e.tgt = ins[3] ? ipc + imm_j : (a + imm_i) & ~32'd1;
            end
        endcase
        e.rw = e.rw && (e.rd != 5'd0);
        return e;
    endfunction

    function automatic logic [31:0] rand_alu();
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        f3 = 3'(rnd(3));
        alt = 1'(rnd(1));
        imm = 12'(rnd(12));
        if (rnd(1))
            return {1'b0, alt && (f3 == 0 || f3 == 5), 5'b0, 5'(rnd(5)), 5'(rnd(5)), f3,
                    5'(rnd(5)), 7'b0110011};
        if (f3 == 3'd1)
            imm = {7'b0, imm[4:0]};
        else if (f3 == 3'd5)
            imm = {1'b0, alt, 5'b0, imm[4:0]};
        return {imm, 5'(rnd(5)), f3, 5'(rnd(5)), 7'b0010011};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_outputs(input exp_t e);
        if (e.chk_alu)
            check("ex_alu_result", ex_alu_result, e.alu);
        check("ex_store_data", ex_store_data, e.sdata);
        check("ex_rd", {27'b0, ex_rd}, {27'b0, e.rd});
        check("ex_reg_write", {31'b0, ex_reg_write}, {31'b0, e.rw});
        check("ex_mem_read", {31'b0, ex_mem_read}, {31'b0, e.mr});
        check("ex_mem_write", {31'b0, ex_mem_write}, {31'b0, e.mw});
        check("ex_mem_to_reg", {31'b0, ex_mem_to_reg}, {31'b0, e.m2r});
        check("ex_redirect", {31'b0, ex_redirect}, {31'b0, e.redir});
        if (e.chk_tgt)
            check("ex_target", ex_target, e.tgt);
    endtask

    function automatic exp_t snap();
        exp_t s;
        s = '0;
        s.alu = ex_alu_result;
        s.sdata = ex_store_data;
        s.tgt = ex_target;
        s.rd = ex_rd;
        {s.rw, s.mr, s.mw, s.m2r, s.redir} = {ex_reg_write, ex_mem_read, ex_mem_write,
                                              ex_mem_to_reg, ex_redirect};
        {s.chk_alu, s.chk_tgt} = 2'b11;
        return s;
    endfunction

    // One cycle of stimulus; a stalled instruction is dropped and not expected
    task automatic step(input logic [31:0] ins, input logic st, input logic we,
                        input logic [4:0] wr, input logic [31:0] wd);
        exp_t e;
        @(posedge clk);
        #1;
        instr = ins;
        pc = cur_pc;
        stall = st;
        {wb_en, wb_rd, wb_data} = {we, wr, wd};
        if (we && wr != 5'd0)
            shadow[wr] = wd;  // Same-cycle write-through
        if (!st) begin
            e = ref_exec(ins, cur_pc, shadow[ins[19:15]], shadow[ins[24:20]]);
            e.issue = adv;
            q.push_back(e);
            cur_pc += 32'd4;
        end
    endtask

    always @(posedge clk) begin
        stall_seen <= stall;
        if (rst_n && !stall)
            adv <= adv + 1;
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (stall_seen) begin
                compare_outputs(last_snap);  // Held during stall
            end else begin
                while (q.size() > 0 && q[0].issue + 2 < adv) begin
                    errors++;
                    $display("An issued instruction reached the outputs without a compare");
                    void'(q.pop_front());
                end
                if (q.size() > 0 && q[0].issue + 2 == adv)
                    compare_outputs(q.pop_front());
            end
            last_snap = snap();
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [31:0] va [3] = '{32'h0000_1234, 32'hffff_fff0, 32'h0000_0005};
        logic [31:0] vb [3] = '{32'h0000_1234, 32'h0000_0005, 32'hffff_fff0};
        logic [31:0] ins;
        logic [11:0] imm;
        logic [12:0] bimm;
        logic [20:0] jimm;
        exp_t        rst_exp;
        for (int r = 0; r < 32; r++)
            shadow[r] = '0;
        {rst_n, stall, wb_en, wb_rd, wb_data} = '0;
        instr = NOP;
        pc = '0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        rst_exp = '0;  // Every output clear after reset
        {rst_exp.chk_alu, rst_exp.chk_tgt} = 2'b11;
        compare_outputs(rst_exp);

        for (int r = 0; r < 32; r++)  // Preload, x0 included
            step(NOP, 1'b0, 1'b1, r[4:0], rnd(32));
        for (int i = 0; i < 40; i++)
            step(rand_alu(), 1'b0, 1'b0, 5'd0, 32'd0);

        for (int i = 0; i < 8; i++) begin
            imm = 12'(rnd(12));
            case (i % 4)
                0: ins = {20'(rnd(20)), 5'(rnd(5)), 7'b0110111};
                1: ins = {20'(rnd(20)), 5'(rnd(5)), 7'b0010111};
                2: ins = {imm, 5'(rnd(5)), 3'b010, 5'(rnd(5)), 7'b0000011};
                default: ins = {imm[11:5], 5'(rnd(5)), 5'(rnd(5)), 3'b010, imm[4:0],
                                7'b0100011};
            endcase
            step(ins, 1'b0, 1'b0, 5'd0, 32'd0);
        end

        // Equal, less and greater pairs, signed and unsigned orders differ
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 3; p++) begin
                step(NOP, 1'b0, 1'b1, 5'd1, va[p]);
                step(NOP, 1'b0, 1'b1, 5'd2, vb[p]);
                bimm = {12'(rnd(12)), 1'b0};
                step({bimm[12], bimm[10:5], 5'd2, 5'd1, br_f3[f], bimm[4:1], bimm[11],
                      7'b1100011}, 1'b0, 1'b0, 5'd0, 32'd0);
            end
        end
        for (int i = 0; i < 2; i++) begin
            jimm = {20'(rnd(20)), 1'b0};
            step({jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'(rnd(5)), 7'b1101111},
                 1'b0, 1'b0, 5'd0, 32'd0);
            step({12'(rnd(12)), 5'(rnd(5)), 3'b000, 5'(rnd(5)), 7'b1100111},
                 1'b0, 1'b0, 5'd0, 32'd0);
        end

        for (int i = 0; i < 30; i++) begin
            ins = rand_alu();
            while (rnd(2) == 0)
                step(ins, 1'b1, 1'b0, 5'd0, 32'd0);  // Dropped, repeated below
            step(ins, 1'b0, 1'b0, 5'd0, 32'd0);
        end

        // add x3, x1, x2 while x1 or x2 is written in the same cycle
        step(32'h0020_81b3, 1'b0, 1'b1, 5'd1, rnd(32));
        step(32'h0020_81b3, 1'b0, 1'b1, 5'd2, rnd(32));

        @(posedge clk);
        #1;
        {instr, stall, wb_en} = {NOP, 1'b0, 1'b0};
        while (q.size() > 0)
            @(negedge clk);
        @(negedge clk);
        $display("Checks %0d, errors %0d", n_checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
rv_pkg.sv
id_ex_if.sv
decode_stage.sv
id_ex_buffer.sv
execute_stage.sv
rv_id_ex_top.sv
tb_clkgen.sv
tb_rv_id_ex.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_rv_id_ex
FILELIST  ?= sim.f

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := rv_defs.svh
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
